// File: files.f
packet_pkg.sv
udp_descriptor_decoder.sv
udp_payload_buffer.sv
ipv4_header_checksum.sv
frame_check_sequence_generator.sv
ethernet_frame_generator.sv
virtual_port_udp_tx.sv
tb_clock_gen.sv
virtual_port_udp_checker.sv
virtual_port_udp_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = virtual_port_udp_tb
FILELIST  = files.f
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: virtual_port_udp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module virtual_port_udp_tb import packet_pkg::*; ();

    typedef byte_t frame_t[$];

    // 100 bytes, short padded frame, 100 bytes under random stalls,
    // four back to back around the pad limit, then a full payload
    localparam int FRAME_COUNT = 8;
    localparam int PAYLOAD_SIZES [FRAME_COUNT] = '{100, 5, 100, 17, 18, 19, 46,
                                                   int'(MAX_PAYLOAD)};

    logic          clock;
    logic          rst_n;
    mac_address_t  mac_source;
    ipv4_address_t ipv4_source;
    port_word_t    module_transmit_data;
    logic          module_data_enable;
    logic          transmit_data_enable;
    logic          module_ready;
    port_word_t    transmit_data;
    logic          transmit_data_valid;

    port_word_t expected_words[$];
    int         error_count;
    int         check_count;
    int         frames_sent;
    int         frames_received;
    int         cycle_count;
    int         cycle_limit;
    logic       random_enable;

    tb_clock_gen u_tb_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    virtual_port_udp_tx u_virtual_port_udp_tx (
        .clock                (clock),
        .rst_n                (rst_n),
        .mac_source           (mac_source),
        .ipv4_source          (ipv4_source),
        .module_transmit_data (module_transmit_data),
        .module_data_enable   (module_data_enable),
        .transmit_data_enable (transmit_data_enable),
        .module_ready         (module_ready),
        .transmit_data        (transmit_data),
        .transmit_data_valid  (transmit_data_valid)
    );

    bind virtual_port_udp_tx virtual_port_udp_checker u_checker (
        .clock                (clock),
        .rst_n                (rst_n),
        .transmit_data        (transmit_data),
        .transmit_data_valid  (transmit_data_valid),
        .transmit_data_enable (transmit_data_enable),
        .module_ready         (module_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference frame model

    // Appends a field, most significant byte first
    function automatic frame_t append_field(input frame_t frame, input logic [47:0] value,
                                            input int count);
        frame_t result;
        result = frame;
        for (int i = count - 1; i >= 0; i--) begin
            result.push_back(value[8*i +: 8]);
        end
        return result;
    endfunction

    function automatic frame_t reference_frame(
        input mac_address_t mac_dst, input mac_address_t mac_src,
        input ipv4_address_t ip_dst, input ipv4_address_t ip_src,
        input word16_t udp_src, input word16_t udp_dst,
        input word16_t identification, input byte_t payload[$]);
        frame_t      frame;
        logic [31:0] sum;
        crc_t        crc;
        word16_t     checksum;
        word16_t     udp_length;
        frame      = {};
        udp_length = 16'(8 + payload.size());
        frame = append_field(frame, mac_dst, 6);
        frame = append_field(frame, mac_src, 6);
        frame = append_field(frame, 48'h0800, 2);               // IPv4 EtherType
        frame = append_field(frame, 48'h4500, 2);               // Version 4, five words
        frame = append_field(frame, 48'(udp_length + 16'd20), 2);
        frame = append_field(frame, 48'(identification), 2);
        frame = append_field(frame, 48'h4000, 2);               // Don't fragment
        frame = append_field(frame, 48'h4011, 2);               // TTL 64, UDP
        frame = append_field(frame, 48'h0000, 2);
        frame = append_field(frame, 48'(ip_src), 4);
        frame = append_field(frame, 48'(ip_dst), 4);
        frame = append_field(frame, 48'(udp_src), 2);
        frame = append_field(frame, 48'(udp_dst), 2);
        frame = append_field(frame, 48'(udp_length), 2);
        frame = append_field(frame, 48'h0000, 2);               // UDP checksum unused
        // Ones' complement sum over the IPv4 header, bytes 14 to 33
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + 32'({frame[i], frame[i+1]});
        end
        while (sum[31:16] != 16'd0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        checksum  = ~sum[15:0];
        frame[24] = checksum[15:8];
        frame[25] = checksum[7:0];
        foreach (payload[i]) begin
            frame.push_back(payload[i]);
        end
        while (frame.size() < 60) begin
            frame.push_back(8'h00);
        end
        crc = 32'hFFFFFFFF;
        foreach (frame[i]) begin
            crc = crc ^ 32'(frame[i]);
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
            end
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            frame.push_back(crc[8*k +: 8]);  // FCS goes out LSB first
        end
        return frame;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and run control

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s is %h, expected %h at cycle %0d", name, actual, expected,
                     cycle_count);
        end
    endtask

    task automatic finish_run();
        error_count += u_virtual_port_udp_tx.u_checker.failure_count;
        $display("checks %0d, errors %0d, frames %0d of %0d", check_count, error_count,
                 frames_received, frames_sent);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic wait_frames_done();
        while (frames_received != frames_sent) begin
            @(negedge clock);
        end
    endtask

    // Holds off while the port is busy with the previous frame
    task automatic write_word(input port_word_t word);
        @(negedge clock);
        while (!module_ready) begin
            module_data_enable = 1'b0;
            @(negedge clock);
        end
        module_transmit_data = word;
        module_data_enable   = 1'b1;
    endtask

    task automatic send_frame(input int length);
        mac_address_t  mac_destination;
        ipv4_address_t ipv4_destination;
        word16_t       udp_source;
        word16_t       udp_destination;
        logic [111:0]  descriptor;
        byte_t         payload[$];
        frame_t        frame;
        mac_destination  = {16'($urandom), $urandom};
        ipv4_destination = $urandom;
        udp_source       = 16'($urandom);
        udp_destination  = 16'($urandom);
        for (int i = 0; i < length; i++) begin
            payload.push_back(8'($urandom));
        end
        frame = reference_frame(mac_destination, mac_source, ipv4_destination, ipv4_source,
                                udp_source, udp_destination, 16'(frames_sent), payload);
        foreach (frame[i]) begin
            expected_words.push_back({i == frame.size() - 1, frame[i]});
        end
        frames_sent++;
        descriptor = {mac_destination, ipv4_destination, udp_source, udp_destination};
        for (int i = 13; i >= 0; i--) begin
            write_word({1'b0, descriptor[8*i +: 8]});
        end
        for (int i = 0; i < length; i++) begin
            write_word({i == length - 1, payload[i]});
        end
        @(negedge clock);
        module_data_enable = 1'b0;
        check_value("module_ready", 32'(module_ready), 32'd0);  // Busy until the FCS is out
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Module side

    initial begin
        void'($urandom(83202));
        error_count          = 0;
        check_count          = 0;
        frames_sent          = 0;
        frames_received      = 0;
        random_enable        = 1'b0;
        module_transmit_data = '0;
        module_data_enable   = 1'b0;
        mac_source           = {16'($urandom), $urandom};
        ipv4_source          = $urandom;
        wait (rst_n === 1'b1);
        check_value("transmit_data_valid", 32'(transmit_data_valid), 32'd0);
        check_value("module_ready", 32'(module_ready), 32'd1);
        for (int i = 0; i < FRAME_COUNT; i++) begin
            if (i == 2 || i == 3) begin
                wait_frames_done();  // Stall pattern only switches between frames
            end
            random_enable = (i == 2);
            send_frame(PAYLOAD_SIZES[i]);
        end
        wait_frames_done();
        repeat (4) @(negedge clock);  // Catch stray bytes after the last FCS
        finish_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Switch side, compares each consumed byte

    initial begin : switch_side
        port_word_t expected_word;
        int         byte_index;
        word16_t    identification;
        logic       ready_pending;
        logic       enable_next;
        transmit_data_enable = 1'b0;
        byte_index           = 0;
        identification       = '0;
        ready_pending        = 1'b0;
        forever begin
            @(negedge clock);
            if (ready_pending) begin
                check_value("module_ready", 32'(module_ready), 32'd1);
                ready_pending = 1'b0;
            end
            enable_next          = random_enable ? 1'($urandom) : 1'b1;
            transmit_data_enable = enable_next;
            if (transmit_data_valid && enable_next) begin
                if (expected_words.size() == 0) begin
                    error_count++;
                    $display("byte %h sent with no frame pending", transmit_data[7:0]);
                end else begin
                    expected_word = expected_words.pop_front();
                    check_value("transmit_data", 32'(transmit_data), 32'(expected_word));
                    if (byte_index == 18) identification[15:8] = transmit_data[7:0];
                    if (byte_index == 19) identification[7:0] = transmit_data[7:0];
                    byte_index++;
                    if (expected_word[8]) begin
                        check_value("ipv4_identification", 32'(identification),
                                    32'(frames_received));
                        frames_received++;
                        byte_index    = 0;
                        ready_pending = 1'b1;
                    end
                end
            end
        end
    end

    // Four cycles per frame byte covers input, stalls and latency
    initial begin : watchdog
        cycle_limit = 2000;
        foreach (PAYLOAD_SIZES[i]) begin
            cycle_limit += 4 * ((PAYLOAD_SIZES[i] < 18 ? 60 : PAYLOAD_SIZES[i] + 42) + 4);
        end
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        error_count++;
        $display("timeout after %0d cycles with frames still outstanding", cycle_limit);
        finish_run();
    end

endmodule

`default_nettype wire

// File: virtual_port_udp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module virtual_port_udp_checker import packet_pkg::*; (
    input logic       clock,
    input logic       rst_n,
    input port_word_t transmit_data,
    input logic       transmit_data_valid,
    input logic       transmit_data_enable,
    input logic       module_ready
);

    int failure_count = 0;

    reset_clears_valid: assert property (@(posedge clock) !rst_n |=> !transmit_data_valid)
        else begin
            failure_count++;
            $error("transmit_data_valid high after reset");
        end

    // Switch stalls the port, so the word on the bus must not move
    data_holds_when_stalled: assert property (@(posedge clock) disable iff (!rst_n)
        (transmit_data_valid && !transmit_data_enable) |=>
            (transmit_data_valid && $stable(transmit_data)))
        else begin
            failure_count++;
            $error("transmit_data changed while stalled");
        end

    ready_low_while_sending: assert property (@(posedge clock) disable iff (!rst_n)
        transmit_data_valid |-> !module_ready)
        else begin
            failure_count++;
            $error("module_ready high during a frame");
        end

    last_only_with_valid: assert property (@(posedge clock) disable iff (!rst_n)
        transmit_data[8] |-> transmit_data_valid)
        else begin
            failure_count++;
            $error("last marker without transmit_data_valid");
        end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period
    end

    // Low for three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: virtual_port_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module virtual_port_udp_tx import packet_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  mac_address_t  mac_source,
    input  ipv4_address_t ipv4_source,
    input  port_word_t    module_transmit_data,   // From fabric module
    input  logic          module_data_enable,
    input  logic          transmit_data_enable,   // Read enable from switch
    output logic          module_ready,
    output port_word_t    transmit_data,          // To switch
    output logic          transmit_data_valid
);

    logic            buffer_write_enable;
    buffer_address_t buffer_write_address;
    byte_t           buffer_write_data;
    buffer_address_t buffer_read_address;
    byte_t           buffer_read_data;
    logic            frame_start;
    logic            frame_sent;
    payload_length_t payload_length;
    mac_address_t    mac_destination;
    ipv4_address_t   ipv4_destination;
    word16_t         udp_source;
    word16_t         udp_destination;
    word16_t         ipv4_identification;
    word16_t         header_checksum;
    logic            checksum_valid;
    logic            crc_clear;
    logic            crc_enable;
    byte_t           crc_data;
    crc_t            crc;

    udp_descriptor_decoder u_udp_descriptor_decoder (
        .clock                (clock),
        .rst_n                (rst_n),
        .module_transmit_data (module_transmit_data),
        .module_data_enable   (module_data_enable),
        .frame_sent           (frame_sent),
        .module_ready         (module_ready),
        .buffer_write_enable  (buffer_write_enable),
        .buffer_write_address (buffer_write_address),
        .buffer_write_data    (buffer_write_data),
        .frame_start          (frame_start),
        .payload_length       (payload_length),
        .mac_destination      (mac_destination),
        .ipv4_destination     (ipv4_destination),
        .udp_source           (udp_source),
        .udp_destination      (udp_destination),
        .ipv4_identification  (ipv4_identification)
    );

    udp_payload_buffer u_udp_payload_buffer (
        .clock         (clock),
        .write_enable  (buffer_write_enable),
        .write_address (buffer_write_address),
        .write_data    (buffer_write_data),
        .read_address  (buffer_read_address),
        .read_data     (buffer_read_data)
    );

    ipv4_header_checksum u_ipv4_header_checksum (
        .clock               (clock),
        .rst_n               (rst_n),
        .frame_start         (frame_start),
        .payload_length      (payload_length),
        .ipv4_source         (ipv4_source),
        .ipv4_destination    (ipv4_destination),
        .ipv4_identification (ipv4_identification),
        .header_checksum     (header_checksum),
        .checksum_valid      (checksum_valid)
    );

    frame_check_sequence_generator u_frame_check_sequence_generator (
        .clock      (clock),
        .rst_n      (rst_n),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .crc_data   (crc_data),
        .crc        (crc)
    );

    ethernet_frame_generator u_ethernet_frame_generator (
        .clock                (clock),
        .rst_n                (rst_n),
        .checksum_valid       (checksum_valid),
        .header_checksum      (header_checksum),
        .payload_length       (payload_length),
        .mac_destination      (mac_destination),
        .mac_source           (mac_source),
        .ipv4_destination     (ipv4_destination),
        .ipv4_source          (ipv4_source),
        .udp_source           (udp_source),
        .udp_destination      (udp_destination),
        .ipv4_identification  (ipv4_identification),
        .buffer_read_data     (buffer_read_data),
        .crc                  (crc),
        .transmit_data_enable (transmit_data_enable),
        .transmit_data        (transmit_data),
        .transmit_data_valid  (transmit_data_valid),
        .buffer_read_address  (buffer_read_address),
        .crc_clear            (crc_clear),
        .crc_enable           (crc_enable),
        .crc_data             (crc_data),
        .frame_sent           (frame_sent)
    );

endmodule

`default_nettype wire

// File: ethernet_frame_generator.sv
`timescale 1ns/1ps
`default_nettype none

module ethernet_frame_generator import packet_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            checksum_valid,
    input  word16_t         header_checksum,
    input  payload_length_t payload_length,
    input  mac_address_t    mac_destination,
    input  mac_address_t    mac_source,
    input  ipv4_address_t   ipv4_destination,
    input  ipv4_address_t   ipv4_source,
    input  word16_t         udp_source,
    input  word16_t         udp_destination,
    input  word16_t         ipv4_identification,
    input  byte_t           buffer_read_data,
    input  crc_t            crc,
    input  logic            transmit_data_enable,
    output port_word_t      transmit_data,
    output logic            transmit_data_valid,
    output buffer_address_t buffer_read_address,
    output logic            crc_clear,
    output logic            crc_enable,
    output byte_t           crc_data,
    output logic            frame_sent
);

    generator_state_t          state;
    payload_length_t           frame_count;   // Bytes consumed before the FCS
    logic [1:0]                fcs_count;
    logic                      consume;
    word16_t                   udp_length;
    word16_t                   total_length;
    payload_length_t           payload_end;
    logic [HEADER_BYTES*8-1:0] header_bits;
    byte_t                     frame_byte;

    assign udp_length   = UDP_HEADER_BYTES + word16_t'(payload_length);
    assign total_length = IPV4_HEADER_BYTES + udp_length;
    assign payload_end  = HEADER_BYTES + payload_length - 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Header bytes, first byte on the wire in the top bits
    assign header_bits = {
        mac_destination, mac_source, ETHERTYPE_IPV4,
        IPV4_VERSION_IHL, 8'h00, total_length, ipv4_identification, IPV4_FLAGS_DF,
        IPV4_TTL, IPV4_PROTOCOL_UDP, header_checksum, ipv4_source, ipv4_destination,
        udp_source, udp_destination, udp_length, 16'h0000   // No UDP checksum
    };

    assign transmit_data_valid = (state != GEN_IDLE);
    assign consume             = transmit_data_valid && transmit_data_enable;

    always_comb begin
        case (state)
            GEN_HEADER:  frame_byte = header_bits[(HEADER_BYTES - 1'b1 - frame_count) * 8 +: 8];
            GEN_PAYLOAD: frame_byte = buffer_read_data;
            GEN_FCS:     frame_byte = ~crc[fcs_count * 8 +: 8];  // LSB first
            default:     frame_byte = 8'h00;  // Idle and pad
        endcase
    end

    assign transmit_data = {(state == GEN_FCS) && (fcs_count == 2'd3), frame_byte};

    // Address leads the shown byte by one cycle to cover the RAM latency
    assign buffer_read_address = frame_count + {10'd0, consume} - HEADER_BYTES;

    assign crc_clear  = (state == GEN_IDLE) && checksum_valid;
    assign crc_enable = consume && (state != GEN_FCS);
    assign crc_data   = frame_byte;
    assign frame_sent = consume && (state == GEN_FCS) && (fcs_count == 2'd3);

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= GEN_IDLE;
            frame_count <= '0;
            fcs_count   <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    frame_count <= '0;
                    fcs_count   <= '0;
                    if (checksum_valid) begin
                        state <= GEN_HEADER;
                    end
                end
                GEN_HEADER: begin
                    if (consume) begin
                        frame_count <= frame_count + 1'b1;
                        if (frame_count == HEADER_BYTES - 1'b1) begin
                            state <= GEN_PAYLOAD;
                        end
                    end
                end
                GEN_PAYLOAD: begin
                    if (consume) begin
                        frame_count <= frame_count + 1'b1;
                        if (frame_count == payload_end) begin
                            if (frame_count < MIN_FRAME_BYTES - 1'b1) begin
                                state <= GEN_PAD;  // Short frame
                            end else begin
                                state <= GEN_FCS;
                            end
                        end
                    end
                end
                GEN_PAD: begin
                    if (consume) begin
                        frame_count <= frame_count + 1'b1;
                        if (frame_count == MIN_FRAME_BYTES - 1'b1) begin
                            state <= GEN_FCS;
                        end
                    end
                end
                GEN_FCS: begin
                    if (consume) begin
                        fcs_count <= fcs_count + 1'b1;
                        if (fcs_count == 2'd3) begin
                            state <= GEN_IDLE;
                        end
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: frame_check_sequence_generator.sv
`timescale 1ns/1ps
`default_nettype none

module frame_check_sequence_generator import packet_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  crc_clear,
    input  logic  crc_enable,
    input  byte_t crc_data,
    output crc_t  crc
);

    // One byte of the reflected CRC-32, LSB first
    function automatic crc_t crc_byte(input crc_t current, input byte_t data);
        crc_t value;
        value = current ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            value = value[0] ? ((value >> 1) ^ CRC_POLYNOMIAL) : (value >> 1);
        end
        return value;
    endfunction

    always_ff @(posedge clock) begin
        if (!rst_n || crc_clear) begin
            crc <= CRC_INIT;
        end else if (crc_enable) begin
            crc <= crc_byte(crc, crc_data);
        end
    end

endmodule

`default_nettype wire

// File: ipv4_header_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module ipv4_header_checksum import packet_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            frame_start,
    input  payload_length_t payload_length,
    input  ipv4_address_t   ipv4_source,
    input  ipv4_address_t   ipv4_destination,
    input  word16_t         ipv4_identification,
    output word16_t         header_checksum,
    output logic            checksum_valid
);

    logic [3:0]  word_index;
    logic        busy;
    word16_t     sum;
    word16_t     total_length;
    word16_t     header_word;
    logic [16:0] wide_sum;

    assign total_length = IPV4_HEADER_BYTES + UDP_HEADER_BYTES + word16_t'(payload_length);

    always_comb begin
        case (word_index)
            4'd0:    header_word = {IPV4_VERSION_IHL, 8'h00};
            4'd1:    header_word = total_length;
            4'd2:    header_word = ipv4_identification;
            4'd3:    header_word = IPV4_FLAGS_DF;
            4'd4:    header_word = {IPV4_TTL, IPV4_PROTOCOL_UDP};
            4'd5:    header_word = 16'h0000;  // Checksum field itself
            4'd6:    header_word = ipv4_source[31:16];
            4'd7:    header_word = ipv4_source[15:0];
            4'd8:    header_word = ipv4_destination[31:16];
            default: header_word = ipv4_destination[15:0];
        endcase
    end

    assign wide_sum        = {1'b0, sum} + {1'b0, header_word};
    assign header_checksum = ~sum;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            word_index     <= '0;
            sum            <= '0;
            checksum_valid <= 1'b0;
        end else begin
            checksum_valid <= 1'b0;
            if (frame_start) begin
                busy       <= 1'b1;
                word_index <= '0;
                sum        <= '0;
            end else if (busy) begin
                sum        <= wide_sum[15:0] + {15'd0, wide_sum[16]};  // End-around carry
                word_index <= word_index + 1'b1;
                if (word_index == 4'd9) begin
                    busy           <= 1'b0;
                    checksum_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: udp_payload_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module udp_payload_buffer import packet_pkg::*; (
    input  logic            clock,
    input  logic            write_enable,
    input  buffer_address_t write_address,
    input  byte_t           write_data,
    input  buffer_address_t read_address,
    output byte_t           read_data
);

    byte_t memory [MAX_PAYLOAD];  // Block RAM, one payload deep

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_address] <= write_data;
        end
        read_data <= memory[read_address];  // One cycle read latency
    end

endmodule

`default_nettype wire

// File: udp_descriptor_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module udp_descriptor_decoder import packet_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  port_word_t      module_transmit_data,
    input  logic            module_data_enable,
    input  logic            frame_sent,
    output logic            module_ready,
    output logic            buffer_write_enable,
    output buffer_address_t buffer_write_address,
    output byte_t           buffer_write_data,
    output logic            frame_start,
    output payload_length_t payload_length,
    output mac_address_t    mac_destination,
    output ipv4_address_t   ipv4_destination,
    output word16_t         udp_source,
    output word16_t         udp_destination,
    output word16_t         ipv4_identification
);

    decoder_state_t  state;
    payload_length_t byte_count;
    logic            last_word;

    // A full buffer ends the payload even without the marker
    assign last_word = module_transmit_data[8] || (byte_count == MAX_PAYLOAD - 1'b1);

    assign module_ready         = (state != DECODER_WAIT_SENT);
    assign buffer_write_enable  = module_data_enable && (state == DECODER_PAYLOAD);
    assign buffer_write_address = byte_count;
    assign buffer_write_data    = module_transmit_data[7:0];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state               <= DECODER_DESCRIPTOR;
            byte_count          <= '0;
            frame_start         <= 1'b0;
            ipv4_identification <= '0;
        end else begin
            frame_start <= 1'b0;
            case (state)
                DECODER_DESCRIPTOR: begin
                    if (module_data_enable) begin
                        if (byte_count == DESCRIPTOR_BYTES - 1'b1) begin
                            byte_count <= '0;
                            state      <= DECODER_PAYLOAD;
                        end else begin
                            byte_count <= byte_count + 1'b1;
                        end
                    end
                end
                DECODER_PAYLOAD: begin
                    if (module_data_enable) begin
                        byte_count <= byte_count + 1'b1;
                        if (last_word) begin
                            byte_count  <= '0;
                            frame_start <= 1'b1;
                            state       <= DECODER_WAIT_SENT;
                        end
                    end
                end
                DECODER_WAIT_SENT: begin
                    if (frame_sent) begin
                        ipv4_identification <= ipv4_identification + 1'b1;
                        state               <= DECODER_DESCRIPTOR;
                    end
                end
                default: state <= DECODER_DESCRIPTOR;
            endcase
        end
    end

    // Descriptor arrives MSB first, so shift the whole field chain left
    always_ff @(posedge clock) begin
        if (module_data_enable && state == DECODER_DESCRIPTOR) begin
            {mac_destination, ipv4_destination, udp_source, udp_destination} <=
                {mac_destination[39:0], ipv4_destination, udp_source, udp_destination,
                 module_transmit_data[7:0]};
        end
        if (buffer_write_enable && last_word) begin
            payload_length <= byte_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: packet_pkg.sv
`default_nettype none

package packet_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  port_word_t;         // Bit 8 marks the last word
    typedef logic [47:0] mac_address_t;
    typedef logic [31:0] ipv4_address_t;
    typedef logic [15:0] word16_t;
    typedef logic [10:0] payload_length_t;
    typedef logic [10:0] buffer_address_t;
    typedef logic [31:0] crc_t;

    typedef enum logic [1:0] {
        DECODER_DESCRIPTOR,
        DECODER_PAYLOAD,
        DECODER_WAIT_SENT
    } decoder_state_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_HEADER,
        GEN_PAYLOAD,
        GEN_PAD,
        GEN_FCS
    } generator_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Frame geometry
    localparam payload_length_t DESCRIPTOR_BYTES  = 11'd14;
    localparam payload_length_t MAX_PAYLOAD       = 11'd1472;
    localparam payload_length_t MIN_FRAME_BYTES   = 11'd60;   // Without FCS
    localparam payload_length_t HEADER_BYTES      = 11'd42;   // Ethernet + IPv4 + UDP
    localparam word16_t         IPV4_HEADER_BYTES = 16'd20;
    localparam word16_t         UDP_HEADER_BYTES  = 16'd8;

    ////////////////////////////////////////////////////////////////////////////
    // Protocol constants
    localparam word16_t ETHERTYPE_IPV4    = 16'h0800;
    localparam byte_t   IPV4_VERSION_IHL  = 8'h45;
    localparam byte_t   IPV4_TTL          = 8'd64;
    localparam byte_t   IPV4_PROTOCOL_UDP = 8'd17;
    localparam word16_t IPV4_FLAGS_DF     = 16'h4000;
    localparam crc_t    CRC_POLYNOMIAL    = 32'hEDB88320;  // Reflected form
    localparam crc_t    CRC_INIT          = 32'hFFFFFFFF;

endpackage

`default_nettype wire
